//--- src/McuBusPkg.sv
// One master and four slave banks of 16 words. Queue depth must be a power of two and equal the credit count
`default_nettype none

package McuBusPkg;

	// ------------------------------
	// Bus and CSR widths
	localparam int CsrDataBits = 32;
	localparam int CsrAdrsBits = 8;
	localparam int BusAdrsBits = 8;
	localparam int NumSlaves = 4;
	localparam int SlaveWords = 16;
	localparam int BusCredits = 2;

	// Derived sizes
	localparam int SlaveSelBits = $clog2(NumSlaves);
	localparam int WordSelBits = $clog2(SlaveWords);
	localparam int MemAdrsBits = SlaveSelBits + WordSelBits;
	localparam int MemDepth = NumSlaves * SlaveWords;
	localparam int CreditBits = $clog2(BusCredits + 1);
	localparam int QueuePtrBits = $clog2(BusCredits);

	// ------------------------------
	// CSR byte addresses
	localparam logic [CsrAdrsBits-1:0] CsrWdAdrs = 8'h00;
	localparam logic [CsrAdrsBits-1:0] CsrAdrsAdrs = 8'h04;
	localparam logic [CsrAdrsBits-1:0] CsrCmdAdrs = 8'h08;
	localparam logic [CsrAdrsBits-1:0] CsrRdAdrs = 8'h0C;
	localparam logic [CsrAdrsBits-1:0] CsrStatusAdrs = 8'h10;

	// Status word layout
	localparam int StatBusyBit = 0;
	localparam int StatDropBit = 1;
	localparam int StatDoneLsb = 2;

	// Bus opcode, taken from command bit 1
	typedef enum logic {OpWrite = 1'b0, OpRead = 1'b1} BusOp;

	// Master FSM
	typedef enum logic [1:0] {MsIdle = 2'd0, MsPending = 2'd1, MsWaitRsp = 2'd2} MasterState;

endpackage

`default_nettype wire

//--- src/MicroControllerCsr.sv
// One-cycle read and write latency with no handshake. Commands written while busy are dropped and the drop flag stays set until reset
`timescale 1ns/1ps
`default_nettype none

module MicroControllerCsr
	import McuBusPkg::*;
(
	input  wire logic                   iSysClk,
	input  wire logic                   rst,
	// Processor side
	input  wire logic [CsrDataBits-1:0] wd,
	input  wire logic [CsrAdrsBits-1:0] adrs,
	input  wire logic                   cke,
	output logic [CsrDataBits-1:0]      rd,
	// Toward the bus master
	output logic [CsrDataBits-1:0]      busWd,
	output logic [BusAdrsBits-1:0]      busAdrs,
	output logic                        cmdGo,
	output BusOp                        cmdOp,
	// Auto-update inputs
	input  wire logic                   busy,
	input  wire logic                   rspValid,
	input  wire logic [CsrDataBits-1:0] rspData,
	input  wire logic [NumSlaves-1:0]   slvDone
);

	logic cmdWrite;
	logic goReq;
	logic busyView;
	logic dropNow;
	logic statBusy;
	logic dropReg;
	logic [NumSlaves-1:0] doneReg;
	logic [CsrDataBits-1:0] rdDataReg;
	logic [CsrDataBits-1:0] statusWord;

	// Command register hit with go set
	assign cmdWrite = cke && (adrs == CsrCmdAdrs);
	assign goReq = cmdWrite && wd[0];
	// Pulse in flight counts as busy too
	assign busyView = busy || cmdGo;
	assign dropNow = goReq && busyView;

	// ------------------------------
	// Manual registers
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			busWd <= '0;
			busAdrs <= '0;
			cmdGo <= 1'b0;
			cmdOp <= OpWrite;
		end
		else
		begin
			if (cke && (adrs == CsrWdAdrs))
				busWd <= wd;
			if (cke && (adrs == CsrAdrsAdrs))
				busAdrs <= wd[BusAdrsBits-1:0];
			// Go bit lives one cycle only
			cmdGo <= goReq && !busyView;
			if (cmdWrite)
				cmdOp <= BusOp'(wd[1]);
		end
	end

	// ------------------------------
	// Auto-updated registers
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			statBusy <= 1'b0;
			dropReg <= 1'b0;
			doneReg <= '0;
			rdDataReg <= '0;
		end
		else
		begin
			// Busy shows as soon as a go is written
			statBusy <= busyView || goReq;
			dropReg <= dropReg || dropNow;
			doneReg <= slvDone;
			if (rspValid)
				rdDataReg <= rspData;
		end
	end

	always_comb
	begin
		statusWord = '0;
		statusWord[StatBusyBit] = statBusy;
		statusWord[StatDropBit] = dropReg;
		statusWord[StatDoneLsb +: NumSlaves] = doneReg;
	end

	// Registered read-back, holds on unmapped addresses
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			rd <= '0;
		else
		begin
			case (adrs)
				CsrWdAdrs:     rd <= busWd;
				CsrAdrsAdrs:   rd <= {{(CsrDataBits-BusAdrsBits){1'b0}}, busAdrs};
				CsrCmdAdrs:    rd <= {{(CsrDataBits-2){1'b0}}, cmdOp, cmdGo};
				CsrRdAdrs:     rd <= rdDataReg;
				CsrStatusAdrs: rd <= statusWord;
				default:       rd <= rd;
			endcase
		end
	end

	// Master sees at most one pulse per accepted command
	assert property (@(posedge iSysClk) disable iff (rst) cmdGo |=> !cmdGo)
		else $error("cmdGo held for two cycles");

endmodule

`default_nettype wire

//--- src/BusMasterCtrl.sv
// One transaction at a time. cmdGo is ignored unless idle, and reads hold busy until the response
`timescale 1ns/1ps
`default_nettype none

module BusMasterCtrl
	import McuBusPkg::*;
(
	input  wire logic                   iSysClk,
	input  wire logic                   rst,
	// From the CSR
	input  wire logic                   cmdGo,
	input  wire BusOp                   cmdOp,
	input  wire logic [CsrDataBits-1:0] busWd,
	input  wire logic [BusAdrsBits-1:0] busAdrs,
	output logic                        busy,
	// Request channel
	output logic                        reqValid,
	output BusOp                        reqOp,
	output logic [BusAdrsBits-1:0]      reqAdrs,
	output logic [CsrDataBits-1:0]      reqWd,
	// Return channel
	input  wire logic                   creditRet,
	input  wire logic                   rspValid
);

	MasterState state;
	logic [CreditBits-1:0] creditCnt;
	logic [CreditBits-1:0] creditNext;
	logic canIssue;
	logic issue;
	BusOp opLatch;
	logic [BusAdrsBits-1:0] adrsLatch;
	logic [CsrDataBits-1:0] wdLatch;

	// ------------------------------
	// Credit bookkeeping
	// Spent while reqValid is out, returned on creditRet
	assign creditNext = creditCnt - CreditBits'(reqValid) + CreditBits'(creditRet);
	// Checked against next cycle count so reqValid never meets zero
	assign canIssue = (creditNext != '0);
	assign issue = canIssue && (((state == MsIdle) && cmdGo) || (state == MsPending));

	assign busy = (state != MsIdle) || reqValid;
	assign reqOp = opLatch;
	assign reqAdrs = adrsLatch;
	assign reqWd = wdLatch;

	// Command capture
	always_ff @(posedge iSysClk)
	begin
		if ((state == MsIdle) && cmdGo)
		begin
			opLatch <= cmdOp;
			adrsLatch <= busAdrs;
			wdLatch <= busWd;
		end
	end

	// ------------------------------
	// FSM and credit counter
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state <= MsIdle;
			creditCnt <= CreditBits'(BusCredits);
			reqValid <= 1'b0;
		end
		else
		begin
			creditCnt <= creditNext;
			reqValid <= issue;
			case (state)
				MsIdle:
				begin
					if (cmdGo)
					begin
						if (!canIssue)
							state <= MsPending;
						else if (cmdOp == OpRead)
							state <= MsWaitRsp;
					end
				end
				MsPending:
				begin
					// Out of credits, wait for a return
					if (canIssue)
						state <= (opLatch == OpRead) ? MsWaitRsp : MsIdle;
				end
				MsWaitRsp:
				begin
					if (rspValid)
						state <= MsIdle;
				end
				default:
					state <= MsIdle;
			endcase
		end
	end

	// Flow control guards
	assert property (@(posedge iSysClk) disable iff (rst) reqValid |-> (creditCnt != '0))
		else $error("reqValid with zero credits");
	assert property (@(posedge iSysClk) disable iff (rst) creditCnt <= CreditBits'(BusCredits))
		else $error("credit count above BusCredits");

endmodule

`default_nettype wire

//--- src/BusSlaveBank.sv
// Queue pointers wrap by overflow so BusCredits must be a power of two. Address bits between slave and word select are ignored
`timescale 1ns/1ps
`default_nettype none

module BusSlaveBank
	import McuBusPkg::*;
(
	input  wire logic                   iSysClk,
	input  wire logic                   rst,
	input  wire logic                   slaveStall,
	// Request channel
	input  wire logic                   reqValid,
	input  wire BusOp                   reqOp,
	input  wire logic [BusAdrsBits-1:0] reqAdrs,
	input  wire logic [CsrDataBits-1:0] reqWd,
	// Return channel
	output logic                        creditRet,
	output logic                        rspValid,
	output logic [CsrDataBits-1:0]      rspData,
	output logic [NumSlaves-1:0]        slvDone
);

	BusOp qOp [BusCredits];
	logic [BusAdrsBits-1:0] qAdrs [BusCredits];
	logic [CsrDataBits-1:0] qWd [BusCredits];
	logic [QueuePtrBits-1:0] headPtr;
	logic [QueuePtrBits-1:0] tailPtr;
	logic [CreditBits-1:0] qCount;
	logic [CsrDataBits-1:0] mem [MemDepth];
	logic retire;
	BusOp headOp;
	logic [SlaveSelBits-1:0] headSlave;
	logic [SlaveSelBits-1:0] pushSlave;
	logic [MemAdrsBits-1:0] headIdx;

	// ------------------------------
	// Head decode
	assign headOp = qOp[headPtr];
	assign headSlave = qAdrs[headPtr][BusAdrsBits-1 -: SlaveSelBits];
	assign headIdx = {headSlave, qAdrs[headPtr][WordSelBits-1:0]};
	assign pushSlave = reqAdrs[BusAdrsBits-1 -: SlaveSelBits];

	// Head retires whenever present and not stalled
	assign retire = (qCount != '0) && !slaveStall;
	assign creditRet = retire;
	assign rspValid = retire && (headOp == OpRead);
	assign rspData = mem[headIdx];

	// Queue payload
	always_ff @(posedge iSysClk)
	begin
		if (reqValid)
		begin
			qOp[tailPtr] <= reqOp;
			qAdrs[tailPtr] <= reqAdrs;
			qWd[tailPtr] <= reqWd;
		end
	end

	// Queue pointers and fill level
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			qCount <= '0;
		end
		else
		begin
			if (reqValid)
				tailPtr <= tailPtr + QueuePtrBits'(1);
			if (retire)
				headPtr <= headPtr + QueuePtrBits'(1);
			qCount <= qCount + CreditBits'(reqValid) - CreditBits'(retire);
		end
	end

	// ------------------------------
	// Slave storage, cleared on reset
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			for (int i = 0; i < MemDepth; i++)
				mem[i] <= '0;
		end
		else if (retire && (headOp == OpWrite))
			mem[headIdx] <= qWd[headPtr];
	end

	// Done flags, a new command clears before an older one sets
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			slvDone <= '0;
		else
		begin
			for (int s = 0; s < NumSlaves; s++)
			begin
				if (reqValid && (pushSlave == SlaveSelBits'(s)))
					slvDone[s] <= 1'b0;
				else if (retire && (headSlave == SlaveSelBits'(s)))
					slvDone[s] <= 1'b1;
			end
		end
	end

	// Credits must keep the queue from overflowing
	assert property (@(posedge iSysClk) disable iff (rst)
		reqValid |-> (qCount != CreditBits'(BusCredits)))
		else $error("push into full slave queue");

endmodule

`default_nettype wire

//--- src/McuBusTop.sv
// Single clock domain. slaveStall holds off the slave queue so the master can run out of credits
`timescale 1ns/1ps
`default_nettype none

module McuBusTop
	import McuBusPkg::*;
(
	input  wire logic                   iSysClk,
	input  wire logic                   rst,
	input  wire logic [CsrDataBits-1:0] wd,
	input  wire logic [CsrAdrsBits-1:0] adrs,
	input  wire logic                   cke,
	output logic [CsrDataBits-1:0]      rd,
	input  wire logic                   slaveStall
);

	// ------------------------------
	// CSR to master
	logic [CsrDataBits-1:0] busWd;
	logic [BusAdrsBits-1:0] busAdrs;
	logic cmdGo;
	BusOp cmdOp;
	logic busy;
	// Master to slaves
	logic reqValid;
	BusOp reqOp;
	logic [BusAdrsBits-1:0] reqAdrs;
	logic [CsrDataBits-1:0] reqWd;
	// Slaves back
	logic creditRet;
	logic rspValid;
	logic [CsrDataBits-1:0] rspData;
	logic [NumSlaves-1:0] slvDone;

	MicroControllerCsr csrInst (
		.iSysClk(iSysClk), .rst(rst), .wd(wd), .adrs(adrs), .cke(cke), .rd(rd),
		.busWd(busWd), .busAdrs(busAdrs), .cmdGo(cmdGo), .cmdOp(cmdOp),
		.busy(busy), .rspValid(rspValid), .rspData(rspData), .slvDone(slvDone)
	);

	BusMasterCtrl masterInst (
		.iSysClk(iSysClk), .rst(rst), .cmdGo(cmdGo), .cmdOp(cmdOp),
		.busWd(busWd), .busAdrs(busAdrs), .busy(busy),
		.reqValid(reqValid), .reqOp(reqOp), .reqAdrs(reqAdrs), .reqWd(reqWd),
		.creditRet(creditRet), .rspValid(rspValid)
	);

	BusSlaveBank slaveInst (
		.iSysClk(iSysClk), .rst(rst), .slaveStall(slaveStall),
		.reqValid(reqValid), .reqOp(reqOp), .reqAdrs(reqAdrs), .reqWd(reqWd),
		.creditRet(creditRet), .rspValid(rspValid), .rspData(rspData), .slvDone(slvDone)
	);

endmodule

`default_nettype wire

//--- verification/McuBusChecker.sv
// Expects bus commands only after busy reads 0, except deliberate drops right after a go. Samples rd one edge after each CSR read
`timescale 1ns/1ps
`default_nettype none

module McuBusChecker
	import McuBusPkg::*;
(
	input  wire logic                   iSysClk,
	input  wire logic                   rst,
	input  wire logic [CsrDataBits-1:0] wd,
	input  wire logic [CsrAdrsBits-1:0] adrs,
	input  wire logic                   cke,
	input  wire logic [CsrDataBits-1:0] rd,
	input  wire logic                   waitActive,
	output int                          errCount,
	output int                          checkCount
);

	// ------------------------------
	// CSR mirror
	logic [CsrDataBits-1:0] mWd;
	logic [BusAdrsBits-1:0] mAdrs;
	logic mOp;
	logic goPulse;
	logic [CsrDataBits-1:0] mRdData;
	logic mDrop;
	logic [NumSlaves-1:0] mDone;
	// Done bits whose retire time is not yet known
	logic [NumSlaves-1:0] unsure;
	logic outstanding;
	logic lastWasRead;
	// Slave memory model
	logic [CsrDataBits-1:0] mem [MemDepth];
	// Pending compare
	logic pend;
	logic [CsrAdrsBits-1:0] pendAdrs;
	logic [CsrDataBits-1:0] expVal;
	logic [CsrDataBits-1:0] expMask;
	int waitCycles;
	logic waitReported;

	always @(posedge iSysClk)
	begin
		int s;
		logic [MemAdrsBits-1:0] idx;
		if (rst)
		begin
			mWd = '0;
			mAdrs = '0;
			mOp = 1'b0;
			goPulse = 1'b0;
			mRdData = '0;
			mDrop = 1'b0;
			mDone = '0;
			unsure = '0;
			outstanding = 1'b0;
			lastWasRead = 1'b0;
			pend = 1'b0;
			pendAdrs = '0;
			expVal = '0;
			expMask = '0;
			waitCycles = 0;
			waitReported = 1'b0;
			errCount = 0;
			checkCount = 0;
			for (int i = 0; i < MemDepth; i++)
				mem[i] = '0;
		end
		else
		begin
			// rd still holds the value captured at the previous edge
			if (pend)
			begin
				checkCount++;
				if ((rd & expMask) != (expVal & expMask))
				begin
					$display("ERR rd adrs=%h exp=%h got=%h mask=%h", pendAdrs, expVal, rd, expMask);
					errCount++;
				end
				// Busy seen low ends the outstanding command
				if ((pendAdrs == CsrStatusAdrs) && !rd[StatBusyBit] && outstanding)
				begin
					outstanding = 1'b0;
					// A finished read means every older command retired too
					if (lastWasRead)
						unsure = '0;
				end
			end

			// ------------------------------
			// Expected read-back for this cycle
			pend = 1'b0;
			expMask = '1;
			pendAdrs = adrs;
			if (!cke)
			begin
				pend = 1'b1;
				case (adrs)
					CsrWdAdrs:     expVal = mWd;
					CsrAdrsAdrs:   expVal = {{(CsrDataBits-BusAdrsBits){1'b0}}, mAdrs};
					CsrCmdAdrs:    expVal = {{(CsrDataBits-2){1'b0}}, mOp, goPulse};
					CsrRdAdrs:
					begin
						expVal = mRdData;
						// Response may still be in flight
						if (outstanding)
							pend = 1'b0;
					end
					CsrStatusAdrs:
					begin
						expVal = '0;
						expVal[StatDropBit] = mDrop;
						expVal[StatDoneLsb +: NumSlaves] = mDone;
						if (outstanding)
						begin
							expMask = '0;
							expMask[StatDropBit] = 1'b1;
						end
						else
						begin
							for (int k = 0; k < NumSlaves; k++)
								expMask[StatDoneLsb + k] = !unsure[k];
						end
					end
					default:       pend = 1'b0;
				endcase
			end

			// ------------------------------
			// Apply processor writes
			goPulse = 1'b0;
			if (cke)
			begin
				case (adrs)
					CsrWdAdrs:   mWd = wd;
					CsrAdrsAdrs: mAdrs = wd[BusAdrsBits-1:0];
					CsrCmdAdrs:
					begin
						mOp = wd[1];
						if (wd[0] && outstanding)
							mDrop = 1'b1;
						else if (wd[0])
						begin
							outstanding = 1'b1;
							lastWasRead = wd[1];
							goPulse = 1'b1;
							s = int'(mAdrs[BusAdrsBits-1 -: SlaveSelBits]);
							idx = {mAdrs[BusAdrsBits-1 -: SlaveSelBits], mAdrs[WordSelBits-1:0]};
							unsure[s] = 1'b1;
							mDone[s] = 1'b1;
							if (wd[1])
								mRdData = mem[idx];
							else
								mem[idx] = mWd;
						end
					end
					default: ;
				endcase
			end

			// Wait rows must see busy fall
			if (waitActive)
			begin
				waitCycles++;
				if ((waitCycles > 200) && !waitReported)
				begin
					$display("busy never fell within 200 cycles of a wait row");
					errCount++;
					waitReported = 1'b1;
				end
			end
			else
			begin
				waitCycles = 0;
				waitReported = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/McuBusTb.sv
// Rows run in order and each wait row polls status until busy is 0. Stall is random only on rows that enable it
`timescale 1ns/1ps
`default_nettype none

module McuBusTb
	import McuBusPkg::*;
();

	// Row operations
	localparam int OpCsrWr = 0;
	localparam int OpCsrRd = 1;
	localparam int OpWaitIdle = 2;
	localparam int MaxRows = 128;

	logic iSysClk;
	logic rst;
	logic [CsrDataBits-1:0] wd;
	logic [CsrAdrsBits-1:0] adrs;
	logic cke;
	logic [CsrDataBits-1:0] rd;
	logic slaveStall;
	logic waitActive;
	logic stallOn;
	int errCount;
	int checkCount;
	int cycles = 0;
	int timeoutLimit = 0;

	// ------------------------------
	// Stimulus table
	int rowOp [MaxRows];
	logic [CsrAdrsBits-1:0] rowAdrs [MaxRows];
	logic [CsrDataBits-1:0] rowData [MaxRows];
	logic rowStall [MaxRows];
	int rowCnt = 0;

	McuBusTop dut_i (
		.iSysClk(iSysClk), .rst(rst), .wd(wd), .adrs(adrs), .cke(cke), .rd(rd),
		.slaveStall(slaveStall)
	);

	McuBusChecker checkerInst (
		.iSysClk(iSysClk), .rst(rst), .wd(wd), .adrs(adrs), .cke(cke), .rd(rd),
		.waitActive(waitActive), .errCount(errCount), .checkCount(checkCount)
	);

	// 40 ns clock
	initial
		iSysClk = 1'b0;
	always #20 iSysClk = ~iSysClk;

	// Run limit from table length
	always @(posedge iSysClk)
	begin
		cycles++;
		if ((timeoutLimit > 0) && (cycles >= timeoutLimit))
		begin
			$display("timeout after %0d cycles with the table unfinished checks=%0d errors=%0d",
				cycles, checkCount, errCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic addRow(input int op, input logic [CsrAdrsBits-1:0] a,
		input logic [CsrDataBits-1:0] d, input logic s);
		rowOp[rowCnt] = op;
		rowAdrs[rowCnt] = a;
		rowData[rowCnt] = d;
		rowStall[rowCnt] = s;
		rowCnt++;
	endtask

	// One bus write through the CSR
	task automatic busWrite(input logic [BusAdrsBits-1:0] a, input logic [CsrDataBits-1:0] d,
		input logic s);
		addRow(OpCsrWr, CsrWdAdrs, d, s);
		addRow(OpCsrWr, CsrAdrsAdrs, {24'h0, a}, s);
		addRow(OpCsrWr, CsrCmdAdrs, 32'h1, s);
		addRow(OpWaitIdle, CsrStatusAdrs, 32'h0, s);
	endtask

	// One bus read followed by the read-data register
	task automatic busRead(input logic [BusAdrsBits-1:0] a, input logic s);
		addRow(OpCsrWr, CsrAdrsAdrs, {24'h0, a}, s);
		addRow(OpCsrWr, CsrCmdAdrs, 32'h3, s);
		addRow(OpWaitIdle, CsrStatusAdrs, 32'h0, s);
		addRow(OpCsrRd, CsrRdAdrs, 32'h0, s);
	endtask

	task automatic buildTable;
		// Reset values
		addRow(OpCsrRd, CsrStatusAdrs, 32'h0, 1'b0);
		addRow(OpCsrRd, CsrRdAdrs, 32'h0, 1'b0);
		addRow(OpCsrRd, CsrWdAdrs, 32'h0, 1'b0);
		addRow(OpCsrRd, CsrAdrsAdrs, 32'h0, 1'b0);
		addRow(OpCsrRd, CsrCmdAdrs, 32'h0, 1'b0);
		// Manual register read-back
		addRow(OpCsrWr, CsrWdAdrs, 32'hDEADBEEF, 1'b0);
		addRow(OpCsrRd, CsrWdAdrs, 32'h0, 1'b0);
		addRow(OpCsrWr, CsrAdrsAdrs, 32'h5A, 1'b0);
		addRow(OpCsrRd, CsrAdrsAdrs, 32'h0, 1'b0);
		// Write then read slave 0 with the go bit self-clearing
		busWrite(8'h03, 32'h12345678, 1'b0);
		addRow(OpCsrRd, CsrCmdAdrs, 32'h0, 1'b0);
		busRead(8'h03, 1'b0);
		addRow(OpCsrRd, CsrStatusAdrs, 32'h0, 1'b0);
		// ------------------------------
		// All four slaves plus a never-written word
		busWrite(8'h42, 32'h11110042, 1'b0);
		busWrite(8'h81, 32'h22220081, 1'b0);
		busWrite(8'hCF, 32'h333300CF, 1'b0);
		busWrite(8'h0A, 32'h0000000A, 1'b0);
		busRead(8'h42, 1'b0);
		busRead(8'h81, 1'b0);
		busRead(8'hCF, 1'b0);
		busRead(8'h0A, 1'b0);
		busRead(8'h85, 1'b0);
		addRow(OpCsrRd, CsrStatusAdrs, 32'h0, 1'b0);
		// ------------------------------
		// Second go while busy is dropped under stall
		addRow(OpCsrWr, CsrWdAdrs, 32'hAAAA0001, 1'b1);
		addRow(OpCsrWr, CsrAdrsAdrs, 32'h44, 1'b1);
		addRow(OpCsrWr, CsrCmdAdrs, 32'h1, 1'b1);
		addRow(OpCsrWr, CsrWdAdrs, 32'hBBBB0002, 1'b1);
		addRow(OpCsrWr, CsrCmdAdrs, 32'h1, 1'b1);
		addRow(OpWaitIdle, CsrStatusAdrs, 32'h0, 1'b1);
		busRead(8'h44, 1'b1);
		addRow(OpCsrRd, CsrStatusAdrs, 32'h0, 1'b1);
		// Back to back under stall
		busWrite(8'hC2, 32'hC0FFEE01, 1'b1);
		busWrite(8'hC2, 32'hC0FFEE02, 1'b1);
		busRead(8'hC2, 1'b1);
		busRead(8'h0A, 1'b1);
		addRow(OpCsrRd, CsrStatusAdrs, 32'h0, 1'b0);
	endtask

	// Falling-edge drive with a fresh stall draw each cycle
	task automatic tick;
		@(negedge iSysClk);
		slaveStall = stallOn && (($urandom % 2) == 1);
	endtask

	task automatic applyRow(input int i);
		int polls;
		stallOn = rowStall[i];
		tick();
		adrs = rowAdrs[i];
		wd = rowData[i];
		cke = (rowOp[i] == OpCsrWr);
		if (rowOp[i] == OpWaitIdle)
		begin
			waitActive = 1'b1;
			polls = 0;
			// First sample reflects the status address
			do
			begin
				tick();
				polls++;
			end
			while (rd[StatBusyBit] && (polls < 210));
			waitActive = 1'b0;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		wd = '0;
		adrs = '0;
		cke = 1'b0;
		slaveStall = 1'b0;
		waitActive = 1'b0;
		stallOn = 1'b0;
		void'($urandom(32'h5685));
		buildTable();
		timeoutLimit = rowCnt * 220;
		repeat (5) @(posedge iSysClk);
		@(negedge iSysClk);
		rst = 1'b0;
		for (int i = 0; i < rowCnt; i++)
			applyRow(i);
		// Let the last compare land
		stallOn = 1'b0;
		cke = 1'b0;
		adrs = 8'hFC;
		repeat (3) tick();
		$display("checks=%0d errors=%0d", checkCount, errCount);
		if ((errCount == 0) && (checkCount > 0))
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/McuBusPkg.sv
src/MicroControllerCsr.sv
src/BusMasterCtrl.sv
src/BusSlaveBank.sv
src/McuBusTop.sv
verification/McuBusChecker.sv
verification/McuBusTb.sv

//--- Makefile
# Verilator simulation of the MCU bus project

VERILATOR ?= verilator
TOP       ?= McuBusTb
FILELIST  ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
